//--- hdl/main_bus_cfg.svh
// main bus configuration
`ifndef MAIN_BUS_CFG_SVH
`define MAIN_BUS_CFG_SVH

// wishbone address and data widths
`define MAIN_WB_AW 32
`define MAIN_WB_DW 32

// sram depth in words, 1 KiB in total
`define SRAM_WORDS 256

// address map, a slave matches when (addr & mask) == base
`define SRAM_BASE 32'h0000_0000
`define SRAM_MASK 32'hFFFF_FC00

// two gpio registers at offsets 0 and 4
`define GPIO_BASE 32'h0001_0000
`define GPIO_MASK 32'hFFFF_FFF8

// number of gpio pins
`define GPIO_WIDTH 16

`endif

//--- hdl/bus_pkg.sv
// wishbone bus signal types
`default_nettype none

`include "main_bus_cfg.svh"

package bus_pkg;

    // byte address
    typedef logic [`MAIN_WB_AW-1:0] wb_addr_t;

    // one data word
    typedef logic [`MAIN_WB_DW-1:0] wb_data_t;

    // byte enables, one bit per data byte
    typedef logic [`MAIN_WB_DW/8-1:0] wb_sel_t;

    // gpio pin vector
    typedef logic [`GPIO_WIDTH-1:0] gpio_t;

endpackage : bus_pkg

`default_nettype wire

//--- hdl/map_pkg.sv
// address map and arbitration types
`default_nettype none

package map_pkg;

    // master index, 0 is the load/store port and 1 the debug port
    typedef logic master_id_t;

    localparam master_id_t MST_LSU = 1'b0;
    localparam master_id_t MST_DBG = 1'b1;

    // arbiter fsm
    typedef enum logic {IDLE, OWNED} arb_state_t;

    // decoded target of an access
    typedef enum logic [1:0] {SEL_SRAM, SEL_GPIO, SEL_NONE} slave_sel_t;

endpackage : map_pkg

`default_nettype wire

//--- hdl/bus_arbiter.sv
// round-robin bus arbiter
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire logic              clk_i,
    input  wire logic              i_arst_n,

    // master 0, load/store port
    input  wire logic              i_m0_cyc,
    input  wire logic              i_m0_stb,
    input  wire logic              i_m0_we,
    input  bus_pkg::wb_addr_t      i_m0_addr,
    input  bus_pkg::wb_data_t      i_m0_wdata,
    input  bus_pkg::wb_sel_t       i_m0_sel,
    output logic                   o_m0_ack,
    output logic                   o_m0_err,
    output bus_pkg::wb_data_t      o_m0_rdata,

    // master 1, debug port
    input  wire logic              i_m1_cyc,
    input  wire logic              i_m1_stb,
    input  wire logic              i_m1_we,
    input  bus_pkg::wb_addr_t      i_m1_addr,
    input  bus_pkg::wb_data_t      i_m1_wdata,
    input  bus_pkg::wb_sel_t       i_m1_sel,
    output logic                   o_m1_ack,
    output logic                   o_m1_err,
    output bus_pkg::wb_data_t      o_m1_rdata,

    // shared bus
    output logic                   o_cyc,
    output logic                   o_stb,
    output logic                   o_we,
    output bus_pkg::wb_addr_t      o_addr,
    output bus_pkg::wb_data_t      o_wdata,
    output bus_pkg::wb_sel_t       o_sel,
    input  wire logic              i_ack,
    input  wire logic              i_err,
    input  bus_pkg::wb_data_t      i_rdata
);

    import map_pkg::*;

    arb_state_t state_q;
    master_id_t owner_q;
    master_id_t last_q;
    master_id_t winner;
    logic       granted;
    logic       owner_cyc;

    // with two requesters the one that did not own the bus last wins
    always_comb begin
        if (i_m0_cyc && i_m1_cyc) begin
            winner = ~last_q;
        end else if (i_m1_cyc) begin
            winner = MST_DBG;
        end else begin
            winner = MST_LSU;
        end
    end

    assign owner_cyc = (owner_q == MST_DBG) ? i_m1_cyc : i_m0_cyc;
    assign granted   = (state_q == OWNED);

    always_ff @(posedge clk_i or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= IDLE;
            owner_q <= MST_LSU;
            last_q  <= MST_LSU;
        end else begin
            case (state_q)
                IDLE: begin
                    if (i_m0_cyc || i_m1_cyc) begin
                        state_q <= OWNED;
                        owner_q <= winner;
                    end
                end
                OWNED: begin
                    // owner releases the bus by dropping cyc
                    if (!owner_cyc) begin
                        state_q <= IDLE;
                        last_q  <= owner_q;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // forward the owner's request, nothing reaches the bus while idle
    always_comb begin
        if (owner_q == MST_DBG) begin
            o_cyc   = granted & i_m1_cyc;
            o_stb   = granted & i_m1_stb;
            o_we    = i_m1_we;
            o_addr  = i_m1_addr;
            o_wdata = i_m1_wdata;
            o_sel   = i_m1_sel;
        end else begin
            o_cyc   = granted & i_m0_cyc;
            o_stb   = granted & i_m0_stb;
            o_we    = i_m0_we;
            o_addr  = i_m0_addr;
            o_wdata = i_m0_wdata;
            o_sel   = i_m0_sel;
        end
    end

    // the waiting master sees ack and err low and keeps stb up
    assign o_m0_ack   = granted & (owner_q == MST_LSU) & i_ack;
    assign o_m0_err   = granted & (owner_q == MST_LSU) & i_err;
    assign o_m0_rdata = (owner_q == MST_LSU) ? i_rdata : '0;
    assign o_m1_ack   = granted & (owner_q == MST_DBG) & i_ack;
    assign o_m1_err   = granted & (owner_q == MST_DBG) & i_err;
    assign o_m1_rdata = (owner_q == MST_DBG) ? i_rdata : '0;

endmodule : bus_arbiter

`default_nettype wire

//--- hdl/bus_decoder.sv
// bus address decoder
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_cfg.svh"

module bus_decoder (
    input  wire logic              clk_i,
    input  wire logic              i_arst_n,

    // shared bus request
    input  wire logic              i_cyc,
    input  wire logic              i_stb,
    input  bus_pkg::wb_addr_t      i_addr,

    // per-slave strobes
    output logic                   o_sram_stb,
    output logic                   o_gpio_stb,

    // slave returns
    input  wire logic              i_sram_ack,
    input  wire logic              i_gpio_ack,
    input  bus_pkg::wb_data_t      i_sram_rdata,
    input  bus_pkg::wb_data_t      i_gpio_rdata,

    // combined return to the arbiter
    output logic                   o_ack,
    output logic                   o_err,
    output bus_pkg::wb_data_t      o_rdata
);

    import map_pkg::*;

    slave_sel_t target;
    logic       req;
    logic       err_q;

    always_comb begin
        if ((i_addr & `SRAM_MASK) == `SRAM_BASE) begin
            target = SEL_SRAM;
        end else if ((i_addr & `GPIO_MASK) == `GPIO_BASE) begin
            target = SEL_GPIO;
        end else begin
            target = SEL_NONE;
        end
    end

    assign req        = i_cyc & i_stb;
    assign o_sram_stb = req & (target == SEL_SRAM);
    assign o_gpio_stb = req & (target == SEL_GPIO);

    // unmapped access, answered like a slave ack but as err
    always_ff @(posedge clk_i or negedge i_arst_n) begin
        if (!i_arst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req & (target == SEL_NONE) & ~err_q;
        end
    end

    assign o_err = err_q;

    // master holds addr until ack, so the target is still valid here
    always_comb begin
        case (target)
            SEL_SRAM: begin
                o_ack   = i_sram_ack;
                o_rdata = i_sram_rdata;
            end
            SEL_GPIO: begin
                o_ack   = i_gpio_ack;
                o_rdata = i_gpio_rdata;
            end
            default: begin
                o_ack   = 1'b0;
                o_rdata = '0;
            end
        endcase
    end

endmodule : bus_decoder

`default_nettype wire

//--- hdl/sram_slave.sv
// word-wide sram slave
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_cfg.svh"

module sram_slave (
    input  wire logic              clk_i,
    input  wire logic              i_arst_n,
    input  wire logic              i_stb,
    input  wire logic              i_we,
    input  bus_pkg::wb_addr_t      i_addr,
    input  bus_pkg::wb_data_t      i_wdata,
    input  bus_pkg::wb_sel_t       i_sel,
    output logic                   o_ack,
    output bus_pkg::wb_data_t      o_rdata
);

    import bus_pkg::*;

    localparam int IDX_W = $clog2(`SRAM_WORDS);

    wb_data_t         mem [`SRAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             ack_q;
    logic             take;

    // word index, byte offset bits dropped
    assign idx  = i_addr[IDX_W+1:2];
    // a strobe still high in the ack cycle is not a new access
    assign take = i_stb & ~ack_q;

    always_ff @(posedge clk_i) begin
        if (take) begin
            if (i_we) begin
                for (int b = 0; b < `MAIN_WB_DW/8; b++) begin
                    if (i_sel[b]) begin
                        mem[idx][8*b +: 8] <= i_wdata[8*b +: 8];
                    end
                end
            end
            o_rdata <= mem[idx];
        end
    end

    always_ff @(posedge clk_i or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;
        end
    end

    assign o_ack = ack_q;

endmodule : sram_slave

`default_nettype wire

//--- hdl/gpio_slave.sv
// gpio slave
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_cfg.svh"

module gpio_slave (
    input  wire logic              clk_i,
    input  wire logic              i_arst_n,
    input  wire logic              i_stb,
    input  wire logic              i_we,
    input  bus_pkg::wb_addr_t      i_addr,
    input  bus_pkg::wb_data_t      i_wdata,
    input  bus_pkg::wb_sel_t       i_sel,
    input  bus_pkg::gpio_t         i_gpio,
    output bus_pkg::gpio_t         o_gpio,
    output logic                   o_ack,
    output bus_pkg::wb_data_t      o_rdata
);

    import bus_pkg::*;

    localparam int PAD_W = `MAIN_WB_DW - `GPIO_WIDTH;

    gpio_t out_q;
    gpio_t sync_q1;
    gpio_t sync_q2;
    logic  ack_q;
    logic  take;
    logic  in_reg;

    assign take   = i_stb & ~ack_q;
    // offset 4 is the input readback
    assign in_reg = i_addr[2];

    always_ff @(posedge clk_i or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ack_q   <= 1'b0;
            out_q   <= '0;
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            ack_q   <= take;
            sync_q1 <= i_gpio;
            sync_q2 <= sync_q1;
            if (take && i_we && !in_reg) begin
                for (int b = 0; b < `GPIO_WIDTH/8; b++) begin
                    if (i_sel[b]) begin
                        out_q[8*b +: 8] <= i_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            o_rdata <= in_reg ? {{PAD_W{1'b0}}, sync_q2} : {{PAD_W{1'b0}}, out_q};
        end
    end

    assign o_gpio = out_q;
    assign o_ack  = ack_q;

endmodule : gpio_slave

`default_nettype wire

//--- hdl/main_bus_top.sv
// main bus with two masters and two slaves
`timescale 1ns/1ps
`default_nettype none

module main_bus_top (
    input  wire logic              clk_i,
    input  wire logic              i_arst_n,

    // master 0, load/store port
    input  wire logic              i_m0_cyc,
    input  wire logic              i_m0_stb,
    input  wire logic              i_m0_we,
    input  bus_pkg::wb_addr_t      i_m0_addr,
    input  bus_pkg::wb_data_t      i_m0_wdata,
    input  bus_pkg::wb_sel_t       i_m0_sel,
    output logic                   o_m0_ack,
    output logic                   o_m0_err,
    output bus_pkg::wb_data_t      o_m0_rdata,

    // master 1, debug port
    input  wire logic              i_m1_cyc,
    input  wire logic              i_m1_stb,
    input  wire logic              i_m1_we,
    input  bus_pkg::wb_addr_t      i_m1_addr,
    input  bus_pkg::wb_data_t      i_m1_wdata,
    input  bus_pkg::wb_sel_t       i_m1_sel,
    output logic                   o_m1_ack,
    output logic                   o_m1_err,
    output bus_pkg::wb_data_t      o_m1_rdata,

    input  bus_pkg::gpio_t         i_gpio,
    output bus_pkg::gpio_t         o_gpio
);

    import bus_pkg::*;

    // shared bus after arbitration
    logic     bus_cyc;
    logic     bus_stb;
    logic     bus_we;
    wb_addr_t bus_addr;
    wb_data_t bus_wdata;
    wb_sel_t  bus_sel;
    logic     bus_ack;
    logic     bus_err;
    wb_data_t bus_rdata;

    // slave side
    logic     sram_stb;
    logic     sram_ack;
    wb_data_t sram_rdata;
    logic     gpio_stb;
    logic     gpio_ack;
    wb_data_t gpio_rdata;

    bus_arbiter arbiter0 (
        .clk_i      (clk_i),
        .i_arst_n   (i_arst_n),
        .i_m0_cyc   (i_m0_cyc),
        .i_m0_stb   (i_m0_stb),
        .i_m0_we    (i_m0_we),
        .i_m0_addr  (i_m0_addr),
        .i_m0_wdata (i_m0_wdata),
        .i_m0_sel   (i_m0_sel),
        .o_m0_ack   (o_m0_ack),
        .o_m0_err   (o_m0_err),
        .o_m0_rdata (o_m0_rdata),
        .i_m1_cyc   (i_m1_cyc),
        .i_m1_stb   (i_m1_stb),
        .i_m1_we    (i_m1_we),
        .i_m1_addr  (i_m1_addr),
        .i_m1_wdata (i_m1_wdata),
        .i_m1_sel   (i_m1_sel),
        .o_m1_ack   (o_m1_ack),
        .o_m1_err   (o_m1_err),
        .o_m1_rdata (o_m1_rdata),
        .o_cyc      (bus_cyc),
        .o_stb      (bus_stb),
        .o_we       (bus_we),
        .o_addr     (bus_addr),
        .o_wdata    (bus_wdata),
        .o_sel      (bus_sel),
        .i_ack      (bus_ack),
        .i_err      (bus_err),
        .i_rdata    (bus_rdata)
    );

    bus_decoder decoder0 (
        .clk_i        (clk_i),
        .i_arst_n     (i_arst_n),
        .i_cyc        (bus_cyc),
        .i_stb        (bus_stb),
        .i_addr       (bus_addr),
        .o_sram_stb   (sram_stb),
        .o_gpio_stb   (gpio_stb),
        .i_sram_ack   (sram_ack),
        .i_gpio_ack   (gpio_ack),
        .i_sram_rdata (sram_rdata),
        .i_gpio_rdata (gpio_rdata),
        .o_ack        (bus_ack),
        .o_err        (bus_err),
        .o_rdata      (bus_rdata)
    );

    sram_slave sram0 (
        .clk_i    (clk_i),
        .i_arst_n (i_arst_n),
        .i_stb    (sram_stb),
        .i_we     (bus_we),
        .i_addr   (bus_addr),
        .i_wdata  (bus_wdata),
        .i_sel    (bus_sel),
        .o_ack    (sram_ack),
        .o_rdata  (sram_rdata)
    );

    gpio_slave gpio0 (
        .clk_i    (clk_i),
        .i_arst_n (i_arst_n),
        .i_stb    (gpio_stb),
        .i_we     (bus_we),
        .i_addr   (bus_addr),
        .i_wdata  (bus_wdata),
        .i_sel    (bus_sel),
        .i_gpio   (i_gpio),
        .o_gpio   (o_gpio),
        .o_ack    (gpio_ack),
        .o_rdata  (gpio_rdata)
    );

endmodule : main_bus_top

`default_nettype wire

//--- tb/main_bus_tb.sv
// main bus testbench
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_cfg.svh"

module main_bus_tb;

    import bus_pkg::*;

    localparam int N_FIXED     = 13;
    localparam int N_RND       = 8;
    localparam int N_ENT       = N_FIXED + 2 * N_RND;
    localparam int TIMEOUT_CYC = N_ENT * 8 + 100;
    localparam int PAD_W       = `MAIN_WB_DW - `GPIO_WIDTH;

    logic     clk;
    logic     arst_n;
    logic     m0_cyc, m0_stb, m0_we, m0_ack, m0_err;
    wb_addr_t m0_addr;
    wb_data_t m0_wdata, m0_rdata;
    wb_sel_t  m0_sel;
    logic     m1_cyc, m1_stb, m1_we, m1_ack, m1_err;
    wb_addr_t m1_addr;
    wb_data_t m1_wdata, m1_rdata;
    wb_sel_t  m1_sel;
    gpio_t    gpio_in;
    gpio_t    gpio_out;

    // access table with expected values filled in as entries are added
    logic     t_master    [N_ENT];
    logic     t_we        [N_ENT];
    wb_addr_t t_addr      [N_ENT];
    wb_data_t t_wdata     [N_ENT];
    wb_sel_t  t_sel       [N_ENT];
    wb_data_t t_exp_rdata [N_ENT];
    logic     t_chk_rdata [N_ENT];
    logic     t_exp_err   [N_ENT];
    gpio_t    t_exp_pins  [N_ENT];
    logic     t_conc      [N_ENT];
    time      done_t      [N_ENT];
    int       n_ent;
    int       cycles = 0;

    // reference contents of the sram and the gpio output register
    wb_data_t sram_model [`SRAM_WORDS];
    gpio_t    gpio_model;

    main_bus_top dut0 (
        .clk_i      (clk),
        .i_arst_n   (arst_n),
        .i_m0_cyc   (m0_cyc),
        .i_m0_stb   (m0_stb),
        .i_m0_we    (m0_we),
        .i_m0_addr  (m0_addr),
        .i_m0_wdata (m0_wdata),
        .i_m0_sel   (m0_sel),
        .o_m0_ack   (m0_ack),
        .o_m0_err   (m0_err),
        .o_m0_rdata (m0_rdata),
        .i_m1_cyc   (m1_cyc),
        .i_m1_stb   (m1_stb),
        .i_m1_we    (m1_we),
        .i_m1_addr  (m1_addr),
        .i_m1_wdata (m1_wdata),
        .i_m1_sel   (m1_sel),
        .o_m1_ack   (m1_ack),
        .o_m1_err   (m1_err),
        .o_m1_rdata (m1_rdata),
        .i_gpio     (gpio_in),
        .o_gpio     (gpio_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input wb_data_t got, input wb_data_t exp);
        assert (got === exp) else begin
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h",
                $time, name, got, exp));
        end
    endtask

    // bytes of nw where sel is set and bytes of old elsewhere
    function automatic wb_data_t merge_bytes(input wb_data_t old, input wb_data_t nw,
                                             input wb_sel_t sel);
        wb_data_t res;
        res = old;
        for (int b = 0; b < `MAIN_WB_DW / 8; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic ack_of(input logic m);
        return m ? m1_ack : m0_ack;
    endfunction

    function automatic logic err_of(input logic m);
        return m ? m1_err : m0_err;
    endfunction

    function automatic wb_data_t rdata_of(input logic m);
        return m ? m1_rdata : m0_rdata;
    endfunction

    task automatic add_access(input logic m, input logic we, input wb_addr_t addr,
                              input wb_data_t wdata, input wb_sel_t sel, input logic conc);
        logic [7:0] idx;
        t_master[n_ent]    = m;
        t_we[n_ent]        = we;
        t_addr[n_ent]      = addr;
        t_wdata[n_ent]     = wdata;
        t_sel[n_ent]       = sel;
        t_conc[n_ent]      = conc;
        t_exp_err[n_ent]   = 1'b0;
        t_chk_rdata[n_ent] = !we;
        t_exp_rdata[n_ent] = '0;
        if ((addr & `SRAM_MASK) == `SRAM_BASE) begin
            idx = addr[9:2];
            if (we) begin
                sram_model[idx] = merge_bytes(sram_model[idx], wdata, sel);
            end else begin
                t_exp_rdata[n_ent] = sram_model[idx];
            end
        end else if ((addr & `GPIO_MASK) == `GPIO_BASE) begin
            if (addr[2]) begin
                // writes to the input register are ignored
                t_exp_rdata[n_ent] = {{PAD_W{1'b0}}, gpio_in};
            end else if (we) begin
                gpio_model = gpio_t'(merge_bytes({{PAD_W{1'b0}}, gpio_model}, wdata, sel));
            end else begin
                t_exp_rdata[n_ent] = {{PAD_W{1'b0}}, gpio_model};
            end
        end else begin
            t_exp_err[n_ent]   = 1'b1;
            t_chk_rdata[n_ent] = 1'b0;
        end
        t_exp_pins[n_ent] = gpio_model;
        n_ent++;
    endtask

    task automatic drive_port(input logic m, input logic cyc, input logic stb, input logic we,
                              input wb_addr_t addr, input wb_data_t wdata, input wb_sel_t sel);
        if (m) begin
            m1_cyc   = cyc;
            m1_stb   = stb;
            m1_we    = we;
            m1_addr  = addr;
            m1_wdata = wdata;
            m1_sel   = sel;
        end else begin
            m0_cyc   = cyc;
            m0_stb   = stb;
            m0_we    = we;
            m0_addr  = addr;
            m0_wdata = wdata;
            m0_sel   = sel;
        end
    endtask

    // one classic cycle with the request held until ack or err and the bus released after
    task automatic play_access(input int i);
        logic m;
        m = t_master[i];
        @(posedge clk);
        #1;
        drive_port(m, 1'b1, 1'b1, t_we[i], t_addr[i], t_wdata[i], t_sel[i]);
        do begin
            @(negedge clk);
        end while (!(ack_of(m) || err_of(m)));
        check_word($sformatf("o_m%0d_ack", m), wb_data_t'(ack_of(m)),
                   wb_data_t'(!t_exp_err[i]));
        check_word($sformatf("o_m%0d_err", m), wb_data_t'(err_of(m)),
                   wb_data_t'(t_exp_err[i]));
        if (t_chk_rdata[i]) begin
            check_word($sformatf("o_m%0d_rdata", m), rdata_of(m), t_exp_rdata[i]);
        end
        check_word("o_gpio", wb_data_t'(gpio_out), wb_data_t'(t_exp_pins[i]));
        done_t[i] = $time;
        @(posedge clk);
        #1;
        drive_port(m, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    endtask

    // returns reach only the owner and never both masters at once
    always @(negedge clk) begin
        assert (!(m0_ack && m1_ack)) else begin
            fail_now("both masters saw ack in the same cycle");
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYC) begin
            fail_now("timeout: the table did not finish within the cycle limit");
        end
    end

    initial begin
        int          i;
        logic [7:0]  ridx;
        wb_addr_t    raddr;
        void'($urandom(42688));
        n_ent  = 0;
        arst_n = 1'b0;
        drive_port(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        drive_port(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        gpio_in    = gpio_t'($urandom());
        gpio_model = '0;

        // both masters start together and the debug port wins the first grant
        add_access(1'b1, 1'b1, 32'h0000_0040, 32'hCAFE_F00D, 4'hF, 1'b1);
        add_access(1'b0, 1'b0, 32'h0000_0040, '0, 4'hF, 1'b0);
        add_access(1'b0, 1'b1, 32'h0000_0000, 32'h1234_5678, 4'hF, 1'b0);
        add_access(1'b0, 1'b0, 32'h0000_0000, '0, 4'hF, 1'b0);
        // partial byte write
        add_access(1'b0, 1'b1, 32'h0000_0004, 32'hDEAD_BEEF, 4'hF, 1'b0);
        add_access(1'b1, 1'b1, 32'h0000_0004, 32'hAABB_CCDD, 4'b0101, 1'b0);
        add_access(1'b0, 1'b0, 32'h0000_0004, '0, 4'hF, 1'b0);
        // gpio output and input registers
        add_access(1'b0, 1'b1, `GPIO_BASE, 32'h0000_A55A, 4'hF, 1'b0);
        add_access(1'b1, 1'b0, `GPIO_BASE, '0, 4'hF, 1'b0);
        add_access(1'b0, 1'b0, `GPIO_BASE + 32'd4, '0, 4'hF, 1'b0);
        // unmapped accesses that must leave sram word 0 intact
        add_access(1'b0, 1'b1, 32'h0002_0000, 32'hFFFF_FFFF, 4'hF, 1'b0);
        add_access(1'b0, 1'b0, 32'h0000_0000, '0, 4'hF, 1'b0);
        add_access(1'b1, 1'b0, 32'h0002_0004, '0, 4'hF, 1'b0);
        for (int k = 0; k < N_RND; k++) begin
            ridx  = 8'($urandom_range(255, 0));
            raddr = `SRAM_BASE | wb_addr_t'({ridx, 2'b00});
            add_access(1'b1, 1'b1, raddr, $urandom(), 4'hF, 1'b0);
            add_access(1'b0, 1'b0, raddr, '0, 4'hF, 1'b0);
        end

        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        i = 0;
        while (i < n_ent) begin
            if (t_conc[i]) begin
                fork
                    play_access(i);
                    play_access(i + 1);
                join
                assert (done_t[i] < done_t[i + 1]) else begin
                    fail_now("the master that was not the last owner did not finish first");
                end
                i += 2;
            end else begin
                play_access(i);
                i++;
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule : main_bus_tb

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/bus_pkg.sv
hdl/map_pkg.sv
hdl/bus_arbiter.sv
hdl/bus_decoder.sv
hdl/sram_slave.sv
hdl/gpio_slave.sv
hdl/main_bus_top.sv
tb/main_bus_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = main_bus_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
